//--- hdl/markerScanner.sv
`timescale 1ns/10ps

module markerScanner (
    input  logic             clk,
    input  logic             resetN,
    input  logic             scanClear,
    input  logic             scanValid,
    input  recordPkg::word_t scanWord,
    input  logic             scanLast,
    output logic             scanReady,
    output logic             markerFound,
    output logic             scanDone
);

    import recordPkg::*;

    scanState_t                      state;
    word_t                           shiftReg;
    logic [BIT_IDX_BITS-1:0]         bitCnt;
    logic [$clog2(MARKER_LEN+1)-1:0] runLen;    // Zeros seen in a row
    logic [$clog2(MARKER_LEN+1)-1:0] runNext;
    logic                            lastWord;
    logic                            loadWord;

    always_comb begin
        scanReady = (state == SCAN_IDLE);
        scanDone  = (state == SCAN_DONE);
        loadWord  = scanValid && scanReady;
        runNext   = shiftReg[0] ? '0 : runLen + 1'b1;   // A one breaks the run
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state       <= SCAN_IDLE;
            runLen      <= '0;
            bitCnt      <= '0;
            lastWord    <= 1'b0;
            markerFound <= 1'b0;
        end else if (scanClear) begin
            state       <= SCAN_IDLE;
            runLen      <= '0;
            markerFound <= 1'b0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (loadWord) begin
                        state    <= SCAN_BITS;
                        bitCnt   <= '0;
                        lastWord <= scanLast;
                    end
                end
                SCAN_BITS: begin
                    runLen <= runNext;        // Run carries into the next word
                    bitCnt <= bitCnt + BIT_IDX_BITS'(1);
                    if (runNext == MARKER_LEN) begin
                        markerFound <= 1'b1;
                        state       <= SCAN_DONE;     // Stop early
                    end else if (bitCnt == BIT_IDX_BITS'(WORD_BITS - 1)) begin
                        state <= lastWord ? SCAN_DONE : SCAN_IDLE;
                    end
                end
                SCAN_DONE: begin
                    state <= SCAN_DONE;   // Held until the next clear
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadWord) begin
            shiftReg <= scanWord;
        end else if (state == SCAN_BITS) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (!resetN)
        runLen <= MARKER_LEN);

endmodule

//--- hdl/recordBuffer.sv
`timescale 1ns/10ps

module recordBuffer (
    input  logic              clk,
    input  logic              resetN,
    input  logic              clearCount,
    input  logic              wordStrobe,
    input  recordPkg::word_t  word,
    input  logic              readEn,
    input  recordPkg::addr_t  readAddr,
    output recordPkg::word_t  readData,
    output recordPkg::count_t wordCount
);

    import recordPkg::*;

    word_t mem [DEPTH];
    logic  full;
    logic  doWrite;

    always_comb begin
        full    = (wordCount == COUNT_BITS'(DEPTH));
        doWrite = wordStrobe && !full;     // Extra words are dropped
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wordCount <= '0;
        end else if (clearCount) begin
            wordCount <= '0;
        end else if (doWrite) begin
            wordCount <= wordCount + COUNT_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wordCount[ADDR_BITS-1:0]] <= word;
        end
        if (readEn) begin
            readData <= mem[readAddr];     // Registered read port
        end
    end

    assert property (@(posedge clk) disable iff (!resetN)
        wordCount <= COUNT_BITS'(DEPTH));

endmodule

//--- hdl/recordController.sv
`timescale 1ns/10ps

module recordController (
    input  logic              clk,
    input  logic              resetN,
    input  logic              enable,
    input  logic              checkStart,
    input  logic              playStart,
    input  logic              flushDone,
    input  recordPkg::count_t wordCount,
    input  recordPkg::word_t  readData,
    input  logic              scanReady,
    input  logic              scanDone,
    input  logic              markerFound,
    input  logic              playbackReady,
    output logic              busy,
    output logic              recorderActive,
    output logic              clearCount,
    output logic              readEn,
    output recordPkg::addr_t  readAddr,
    output logic              scanValid,
    output recordPkg::word_t  scanWord,
    output logic              scanLast,
    output logic              scanClear,
    output logic              checkDone,
    output logic              playbackValid,
    output recordPkg::word_t  playbackData,
    output logic              playbackLast
);

    import recordPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       enableD;
    logic       enableRise;
    logic       startRecord;
    logic       startCheck;
    logic       startPlay;
    logic       fetching;
    count_t     fetchIdx;       // Next word to read
    logic       readPending;    // Read data lands this cycle
    word_t      holdWord;
    logic       holdValid;
    logic       holdLast;
    logic       holdTaken;

    always_comb begin
        enableRise  = enable && !enableD;
        startRecord = (state == IDLE) && enableRise;
        startCheck  = (state == IDLE) && !enableRise && checkStart;
        startPlay   = (state == IDLE) && !enableRise && !checkStart && playStart;

        busy           = (state != IDLE);
        recorderActive = startRecord || (state == RECORD) || (state == FLUSH);
        clearCount     = startRecord;
        scanClear      = startRecord || startCheck;
        fetching       = (state == CHECK) || (state == PLAY);

        // One word in flight, the next fetch waits for the holding register
        readEn   = fetching && !holdValid && !readPending
                   && !((state == CHECK) && markerFound)   // Check stops at the marker
                   && (fetchIdx < wordCount);
        readAddr = fetchIdx[ADDR_BITS-1:0];

        scanValid     = (state == CHECK) && holdValid;
        scanWord      = holdWord;
        scanLast      = holdLast;
        playbackValid = (state == PLAY) && holdValid;
        playbackData  = holdWord;
        playbackLast  = holdLast;
        holdTaken     = (scanValid && scanReady) || (playbackValid && playbackReady);
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (startRecord) begin
                    nextState = RECORD;
                end else if (startCheck) begin
                    nextState = CHECK;
                end else if (startPlay) begin
                    nextState = PLAY;
                end
            end
            RECORD: begin
                if (!enable) begin
                    nextState = FLUSH;
                end
            end
            FLUSH: begin
                if (flushDone) begin
                    nextState = IDLE;
                end
            end
            CHECK: begin
                if (scanDone || (wordCount == '0)) begin
                    nextState = IDLE;
                end
            end
            PLAY: begin
                if ((wordCount == '0) || (playbackValid && playbackReady && playbackLast)) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state       <= IDLE;
            enableD     <= 1'b0;
            fetchIdx    <= '0;
            readPending <= 1'b0;
            holdValid   <= 1'b0;
            holdLast    <= 1'b0;
            checkDone   <= 1'b0;
        end else begin
            state       <= nextState;
            enableD     <= enable;
            readPending <= readEn;
            if (startRecord || startCheck || startPlay) begin
                checkDone <= 1'b0;
            end else if ((state == CHECK) && (nextState == IDLE)) begin
                checkDone <= 1'b1;                  // Sticky until next command
            end
            if (!fetching) begin
                fetchIdx  <= '0;
                holdValid <= 1'b0;
            end else begin
                if (readEn) begin
                    fetchIdx <= fetchIdx + COUNT_BITS'(1);
                end
                if (readPending) begin
                    holdValid <= 1'b1;
                    holdLast  <= (fetchIdx == wordCount);   // Index already advanced
                end else if (holdTaken) begin
                    holdValid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetching && readPending) begin
            holdWord <= readData;
        end
    end

    assert property (@(posedge clk) disable iff (!resetN)
        playbackValid && !playbackReady |=> playbackValid && $stable(playbackData));

endmodule

//--- hdl/recordMaster.sv
`timescale 1ns/10ps

module recordMaster (
    input  logic              clk,
    input  logic              resetN,
    input  logic              enable,
    input  logic              samplePulse,
    input  logic              dIn,
    input  logic              checkStart,
    input  logic              playStart,
    input  logic              playbackReady,
    output logic              busy,
    output logic              markerFound,
    output logic              checkDone,
    output recordPkg::count_t wordCount,
    output logic              playbackValid,
    output recordPkg::word_t  playbackData,
    output logic              playbackLast
);

    import recordPkg::*;

    logic  recorderActive;
    logic  wordStrobe;
    word_t packedWord;     // Sampler to buffer
    logic  flushDone;
    logic  clearCount;
    logic  readEn;
    addr_t readAddr;
    word_t readData;
    logic  scanValid;
    word_t scanWord;
    logic  scanLast;
    logic  scanClear;
    logic  scanReady;
    logic  scanDone;

    sampleRecorder sampler (
        .clk, .resetN, .enable, .samplePulse, .dIn,
        .active(recorderActive),
        .wordStrobe,
        .word(packedWord),
        .flushDone
    );

    recordBuffer buffer (
        .clk, .resetN, .clearCount, .wordStrobe,
        .word(packedWord),
        .readEn, .readAddr, .readData, .wordCount
    );

    markerScanner scanner (
        .clk, .resetN, .scanClear, .scanValid, .scanWord, .scanLast,
        .scanReady, .markerFound, .scanDone
    );

    recordController controller (
        .clk, .resetN, .enable, .checkStart, .playStart, .flushDone,
        .wordCount, .readData, .scanReady, .scanDone, .markerFound, .playbackReady,
        .busy, .recorderActive, .clearCount, .readEn, .readAddr,
        .scanValid, .scanWord, .scanLast, .scanClear, .checkDone,
        .playbackValid, .playbackData, .playbackLast
    );

endmodule

//--- hdl/recordPkg.sv
package recordPkg;

    localparam int WORD_BITS    = 32;      // Bits per stored word
    localparam int DEPTH        = 16;      // Words in the buffer
    localparam int ADDR_BITS    = 4;
    localparam int COUNT_BITS   = 5;       // Holds 0 to DEPTH
    localparam int MARKER_LEN   = 6;       // Zero run that ends a message
    localparam int BIT_IDX_BITS = 5;       // Bit position inside a word

    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [COUNT_BITS-1:0] count_t;

    // Top level command FSM
    typedef enum logic [2:0] {
        IDLE,
        RECORD,
        FLUSH,
        CHECK,
        PLAY
    } ctrlState_t;

    // Serial marker scanner
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_BITS,
        SCAN_DONE
    } scanState_t;

endpackage

//--- hdl/sampleRecorder.sv
`timescale 1ns/10ps

module sampleRecorder (
    input  logic             clk,
    input  logic             resetN,
    input  logic             enable,
    input  logic             samplePulse,
    input  logic             dIn,
    input  logic             active,
    output logic             wordStrobe,
    output recordPkg::word_t word,
    output logic             flushDone
);

    import recordPkg::*;

    word_t                   shiftReg;      // Bits collected so far
    word_t                   nextBits;
    word_t                   padMask;
    logic [BIT_IDX_BITS-1:0] bitIdx;
    logic                    enableD;
    logic                    takeSample;
    logic                    enableFall;
    logic                    wordFull;
    logic                    flushPending;

    always_comb begin
        takeSample = active && enable && samplePulse;
        enableFall = active && enableD && !enable;
        wordFull   = (bitIdx == BIT_IDX_BITS'(WORD_BITS - 1));
        nextBits   = shiftReg;
        nextBits[bitIdx] = dIn;               // LSB first
        padMask    = ~((word_t'(1) << bitIdx) - word_t'(1));   // Ones above the last bit
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            bitIdx       <= '0;
            enableD      <= 1'b0;
            wordStrobe   <= 1'b0;
            flushPending <= 1'b0;
            flushDone    <= 1'b0;
        end else begin
            enableD      <= enable;
            wordStrobe   <= 1'b0;
            flushPending <= enableFall;
            flushDone    <= flushPending;          // One cycle behind the padded strobe
            if (!active) begin
                bitIdx <= '0;
            end else if (takeSample) begin
                bitIdx <= bitIdx + BIT_IDX_BITS'(1);   // Wraps to zero after bit 31
                if (wordFull) begin
                    wordStrobe <= 1'b1;
                end
            end else if (enableFall) begin
                bitIdx     <= '0;
                wordStrobe <= (bitIdx != '0);      // Only a partial word is flushed
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeSample) begin
            shiftReg <= nextBits;
        end
        if (takeSample && wordFull) begin
            word <= nextBits;
        end else if (enableFall) begin
            word <= shiftReg | padMask;
        end
    end

    // A full word needs 32 samples and a flush never follows a wrap
    assert property (@(posedge clk) disable iff (!resetN)
        wordStrobe |=> !wordStrobe);

endmodule

//--- src.f
+incdir+tb
hdl/recordPkg.sv
hdl/sampleRecorder.sv
hdl/recordBuffer.sv
hdl/markerScanner.sv
hdl/recordController.sv
hdl/recordMaster.sv
tb/recordMasterTb.sv

//--- tb/recordChecks.svh
`ifndef RECORD_CHECKS_SVH
`define RECORD_CHECKS_SVH

task automatic checkWord(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
        abortRun($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic checkCount(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
        abortRun($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
    end
endtask

task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abortRun($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
    end
endtask

task automatic nextCycle();
    @(posedge clk);
    #1;
endtask

task automatic waitIdle();
    do begin
        @(negedge clk);
    end while (busy);
endtask

// Records the whole queue, optionally with idle cycles between pulses
task automatic recordStream(input logic gapped);
    logic [31:0] r;
    nextCycle();
    enable = 1'b1;
    foreach (bitStream[i]) begin
        nextCycle();
        samplePulse = 1'b0;
        r = nextRandom();
        if (gapped) begin
            repeat (r[1:0]) begin
                nextCycle();
            end
        end
        samplePulse = 1'b1;
        dIn         = bitStream[i];
    end
    nextCycle();
    samplePulse = 1'b0;
    enable      = 1'b0;
    waitIdle();
    buildModel();
endtask

task automatic runCheck(input string name);
    nextCycle();
    checkStart = 1'b1;
    nextCycle();
    checkStart = 1'b0;
    do begin
        @(negedge clk);
    end while (!checkDone);
    checkFlag(name, expMarker, markerFound);
    checkFlag(name, 1'b0, busy);
endtask

task automatic runPlay(input string name, input logic randomReady);
    int          got;
    logic [31:0] r;
    got = 0;
    nextCycle();
    playStart = 1'b1;
    nextCycle();
    playStart = 1'b0;
    while (got < expCount) begin
        r = nextRandom();
        playbackReady = randomReady ? r[8] : 1'b1;
        @(negedge clk);
        if (playbackValid && playbackReady) begin   // Transfer on the coming edge
            gotWords[got] = playbackData;
            checkWord(name, expWords[got], playbackData);
            checkFlag(name, (got == expCount - 1), playbackLast);
            got++;
        end
        nextCycle();
    end
    playbackReady = 1'b0;
    if (expCount != 0) begin
        @(negedge clk);
        checkFlag(name, 1'b0, busy);                 // One cycle after the last word
    end else begin
        do begin
            @(negedge clk);
            checkFlag(name, 1'b0, playbackValid);
        end while (busy);
    end
endtask

task automatic testRecordPlay();
    fillRandom(100);
    recordStream(1'b1);
    checkCount("recordPlay", count_t'(4), wordCount);
    runPlay("recordPlay", 1'b0);
    runCheck("recordPlayCheck");
endtask

task automatic testPadding();
    fillRandom(37);
    recordStream(1'b0);
    checkCount("padding", expCount, wordCount);
    runPlay("padding", 1'b0);
    checkWord("paddingUpper", 32'hFFFF_FFE0, gotWords[1] & 32'hFFFF_FFE0);
endtask

task automatic testMarker();
    bitStream.delete();
    for (int i = 0; i < 64; i++) begin
        bitStream.push_back(!(i >= 29 && i <= 34));  // Zero run spans words 0 and 1
    end
    recordStream(1'b0);
    runCheck("markerAcross");
    runPlay("markerPlay", 1'b0);                     // Playback with the marker flag set
    bitStream.delete();
    repeat (40) begin
        bitStream.push_back(1'b1);
    end
    recordStream(1'b0);
    runCheck("markerAbsent");
endtask

task automatic testBackPressure();
    fillRandom(200);
    recordStream(1'b1);
    checkCount("backPressure", expCount, wordCount);
    runPlay("backPressure", 1'b1);
endtask

task automatic testOverflow();
    fillRandom(530);
    recordStream(1'b0);
    checkCount("overflow", count_t'(DEPTH), wordCount);
    runPlay("overflow", 1'b0);
    bitStream.delete();
    recordStream(1'b0);                              // Enable pulse with no samples
    checkCount("emptyRecord", count_t'(0), wordCount);
    runCheck("emptyCheck");
    runPlay("emptyPlay", 1'b0);
endtask

task automatic fillRandom(input int n);
    logic [31:0] r;
    bitStream.delete();
    repeat (n) begin
        r = nextRandom();
        bitStream.push_back(r[16]);
    end
endtask

`endif

//--- tb/recordMasterTb.sv
`timescale 1ns/10ps

module recordMasterTb;

    import recordPkg::*;

    localparam int MAX_CYCLES = 20000;   // About ten times the longest test sequence

    logic   clk;
    logic   resetN;
    logic   enable;
    logic   samplePulse;
    logic   dIn;
    logic   checkStart;
    logic   playStart;
    logic   playbackReady;
    logic   busy;
    logic   markerFound;
    logic   checkDone;
    count_t wordCount;
    logic   playbackValid;
    word_t  playbackData;
    logic   playbackLast;

    logic [31:0] lcgState;
    int          cycles;
    logic        bitStream[$];       // Bits in the order they are sampled
    word_t       expWords[DEPTH];
    count_t      expCount;
    logic        expMarker;
    word_t       gotWords[DEPTH];    // Words seen on the playback port

    recordMaster uut (
        .clk(clk), .resetN(resetN), .enable(enable), .samplePulse(samplePulse),
        .dIn(dIn), .checkStart(checkStart), .playStart(playStart),
        .playbackReady(playbackReady), .busy(busy), .markerFound(markerFound),
        .checkDone(checkDone), .wordCount(wordCount), .playbackValid(playbackValid),
        .playbackData(playbackData), .playbackLast(playbackLast)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abortRun($sformatf("Timeout, the run went past %0d clock cycles", MAX_CYCLES));
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Expected words and marker result from the bit queue
    task automatic buildModel();
        int run;
        int nBits;
        run       = 0;
        nBits     = (bitStream.size() > DEPTH * WORD_BITS) ? DEPTH * WORD_BITS : bitStream.size();
        expCount  = count_t'((nBits + WORD_BITS - 1) / WORD_BITS);
        expMarker = 1'b0;
        for (int w = 0; w < DEPTH; w++) begin
            expWords[w] = '1;                   // Unused upper bits read as ones
        end
        for (int i = 0; i < nBits; i++) begin
            expWords[i / WORD_BITS][i % WORD_BITS] = bitStream[i];
            run = bitStream[i] ? 0 : run + 1;
            if (run >= MARKER_LEN) begin
                expMarker = 1'b1;
            end
        end
    endtask

    `include "recordChecks.svh"

    initial begin
        clk           = 1'b0;
        resetN        = 1'b0;
        enable        = 1'b0;
        samplePulse   = 1'b0;
        dIn           = 1'b0;
        checkStart    = 1'b0;
        playStart     = 1'b0;
        playbackReady = 1'b0;
        lcgState      = 32'h24da409d;
        cycles        = 0;
        repeat (5) @(posedge clk);
        #1;
        resetN = 1'b1;
        @(negedge clk);
        checkFlag("reset", 1'b0, busy);
        checkFlag("reset", 1'b0, playbackValid);
        checkFlag("reset", 1'b0, checkDone);
        checkFlag("reset", 1'b0, markerFound);
        checkCount("reset", count_t'(0), wordCount);
        testRecordPlay();
        testPadding();
        testMarker();
        testBackPressure();
        testOverflow();
        $display("TEST OK");
        $finish;
    end

endmodule
